//--- all.f
hw/tim_cfg_pkg.sv
hw/cfg_bus_if.sv
hw/apb_reg_decode.sv
hw/timebase_regs.sv
hw/output_stage_regs.sv
hw/read_mux.sv
hw/tim_cfg_top.sv
testbench/tb_clk_gen.sv
testbench/tim_cfg_tb.sv

//--- hw/apb_reg_decode.sv
`timescale 1ns/100ps
`default_nettype none

module apb_reg_decode
    import tim_cfg_pkg::*;
(
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  data_t      pwdata,
    cfg_bus_if.decoder cfg
);

    reg_idx_t idx;
    logic     idx_valid;

    // Full address compare, dropped channel offsets fall to default
    always_comb begin
        idx_valid = 1'b1;
        case (paddr)
            BASE_ADDR + OFS_TOP_CTRL: idx = IDX_TOP_CTRL;
            BASE_ADDR + OFS_PE_CTRL:  idx = IDX_PE_CTRL;
            BASE_ADDR + OFS_PE_CTRL1: idx = IDX_PE_CTRL1;
            BASE_ADDR + OFS_PE_CTRL2: idx = IDX_PE_CTRL2;
            BASE_ADDR + OFS_CH1:      idx = IDX_CH1;
            BASE_ADDR + OFS_CH2:      idx = IDX_CH2;
            BASE_ADDR + OFS_CH3:      idx = IDX_CH3;
            BASE_ADDR + OFS_BRK:      idx = IDX_BRK;
            BASE_ADDR + OFS_INT_EN:   idx = IDX_INT_EN;
            BASE_ADDR + OFS_INT_CLR:  idx = IDX_INT_CLR;
            BASE_ADDR + OFS_INT_STA:  idx = IDX_INT_STA;
            default: begin
                idx       = IDX_TOP_CTRL;
                idx_valid = 1'b0;
            end
        endcase
    end

    // Access phase write, status register is read only
    assign cfg.wr_en = psel && penable && pwrite && idx_valid
                       && (idx != IDX_INT_STA);

    assign cfg.idx       = idx;
    assign cfg.idx_valid = idx_valid;
    assign cfg.wdata     = pwdata;

endmodule

`default_nettype wire

//--- hw/cfg_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded APB access shared by the register banks and the read path
interface cfg_bus_if
    import tim_cfg_pkg::*;
();

    logic     wr_en;
    reg_idx_t idx;
    logic     idx_valid;
    data_t    wdata;

    modport decoder (
        output wr_en,
        output idx,
        output idx_valid,
        output wdata
    );

    modport bank (input wr_en, input idx, input wdata);

    modport reader (input idx, input idx_valid);

endinterface

`default_nettype wire

//--- hw/output_stage_regs.sv
`timescale 1ns/100ps
`default_nettype none

module output_stage_regs
    import tim_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    cfg_bus_if.bank     cfg,
    input  logic [1:0]  int_sta,
    output count_t      ch_compare [NUM_CH],
    output ch_ctrl_t    ch_ctrl [NUM_CH],
    output break_time_t bt,
    output logic        bk2p,
    output logic        bk2e,
    output logic        bk1p,
    output logic        bk1e,
    output dead_time_t  dtg,
    output logic [1:0]  int_en,
    output logic [1:0]  int_clr,
    output data_t       ch_img [NUM_CH],
    output data_t       brk_img,
    output data_t       int_en_img,
    output data_t       int_clr_img,
    output data_t       int_sta_img
);

    logic brk_wr;
    logic int_en_wr;
    logic int_clr_wr;

    assign brk_wr     = cfg.wr_en && (cfg.idx == IDX_BRK);
    assign int_en_wr  = cfg.wr_en && (cfg.idx == IDX_INT_EN);
    assign int_clr_wr = cfg.wr_en && (cfg.idx == IDX_INT_CLR);

    ////////////////////////////////////////////////////////////
    // Complementary output channels
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        logic ch_wr;

        // Channel registers sit on consecutive indices
        assign ch_wr = cfg.wr_en && (cfg.idx == reg_idx_t'(IDX_CH1 + i));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ch_compare[i] <= '0;
                ch_ctrl[i]    <= RST_CH_CTRL;
            end else if (ch_wr) begin
                ch_compare[i] <= cfg.wdata[31:16];
                ch_ctrl[i]    <= cfg.wdata[15:0] & CH_CTRL_MASK;
            end
        end

        assign ch_img[i] = {ch_compare[i], ch_ctrl[i]};
    end

    ////////////////////////////////////////////////////////////
    // Break and dead time
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bt   <= '0;
            bk2p <= 1'b0;
            bk2e <= 1'b0;
            bk1p <= 1'b0;
            bk1e <= 1'b0;
            dtg  <= RST_DTG;
        end else if (brk_wr) begin
            bt   <= cfg.wdata[BRK_BT_LSB +: 4];
            bk2p <= cfg.wdata[BRK_BK2P];
            bk2e <= cfg.wdata[BRK_BK2E];
            bk1p <= cfg.wdata[BRK_BK1P];
            bk1e <= cfg.wdata[BRK_BK1E];
            dtg  <= cfg.wdata[9:0];
        end
    end

    // Interrupt enable and clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_en <= 2'b00;
        end else if (int_en_wr) begin
            int_en <= cfg.wdata[1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_clr <= 2'b00;
        end else if (int_clr_wr) begin
            int_clr <= cfg.wdata[1:0];
        end
    end

    assign brk_img     = {12'h0, bt, 2'b00, bk2p, bk2e, bk1p, bk1e, dtg};
    assign int_en_img  = {30'h0, int_en};
    assign int_clr_img = {30'h0, int_clr};
    // Status comes straight from the timer core
    assign int_sta_img = {30'h0, int_sta};

endmodule

`default_nettype wire

//--- hw/read_mux.sv
`timescale 1ns/100ps
`default_nettype none

module read_mux
    import tim_cfg_pkg::*;
(
    cfg_bus_if.reader cfg,
    input  data_t     top_ctrl_img,
    input  data_t     pe_ctrl_img,
    input  data_t     pe_ctrl1_img,
    input  data_t     pe_ctrl2_img,
    input  data_t     ch_img [NUM_CH],
    input  data_t     brk_img,
    input  data_t     int_en_img,
    input  data_t     int_clr_img,
    input  data_t     int_sta_img,
    output data_t     prdata
);

    // Unmapped addresses read as zero
    always_comb begin
        prdata = '0;
        if (cfg.idx_valid) begin
            case (cfg.idx)
                IDX_TOP_CTRL: prdata = top_ctrl_img;
                IDX_PE_CTRL:  prdata = pe_ctrl_img;
                IDX_PE_CTRL1: prdata = pe_ctrl1_img;
                IDX_PE_CTRL2: prdata = pe_ctrl2_img;
                IDX_CH1:      prdata = ch_img[0];
                IDX_CH2:      prdata = ch_img[1];
                IDX_CH3:      prdata = ch_img[2];
                IDX_BRK:      prdata = brk_img;
                IDX_INT_EN:   prdata = int_en_img;
                IDX_INT_CLR:  prdata = int_clr_img;
                IDX_INT_STA:  prdata = int_sta_img;
                default:      prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/tim_cfg_pkg.sv
`default_nettype none

package tim_cfg_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] count_t;
    typedef logic [15:0] ch_ctrl_t;
    typedef logic [3:0]  oc_mode_t;
    typedef logic [9:0]  dead_time_t;
    typedef logic [3:0]  break_time_t;
    typedef logic [3:0]  reg_idx_t;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////
    localparam addr_t BASE_ADDR    = 32'h4002_1000;

    localparam addr_t OFS_TOP_CTRL = 32'h00;
    localparam addr_t OFS_PE_CTRL  = 32'h04;
    localparam addr_t OFS_PE_CTRL1 = 32'h08;
    localparam addr_t OFS_PE_CTRL2 = 32'h0C;
    localparam addr_t OFS_CH1      = 32'h10;
    localparam addr_t OFS_CH2      = 32'h14;
    localparam addr_t OFS_CH3      = 32'h18;
    localparam addr_t OFS_BRK      = 32'h28;
    localparam addr_t OFS_INT_EN   = 32'h40;
    localparam addr_t OFS_INT_CLR  = 32'h44;
    localparam addr_t OFS_INT_STA  = 32'h48;

    localparam reg_idx_t IDX_TOP_CTRL = 4'd0;
    localparam reg_idx_t IDX_PE_CTRL  = 4'd1;
    localparam reg_idx_t IDX_PE_CTRL1 = 4'd2;
    localparam reg_idx_t IDX_PE_CTRL2 = 4'd3;
    localparam reg_idx_t IDX_CH1      = 4'd4;
    localparam reg_idx_t IDX_CH2      = 4'd5;
    localparam reg_idx_t IDX_CH3      = 4'd6;
    localparam reg_idx_t IDX_BRK      = 4'd7;
    localparam reg_idx_t IDX_INT_EN   = 4'd8;
    localparam reg_idx_t IDX_INT_CLR  = 4'd9;
    localparam reg_idx_t IDX_INT_STA  = 4'd10;

    localparam int NUM_CH = 3;

    ////////////////////////////////////////////////////////////
    // Field positions
    ////////////////////////////////////////////////////////////
    localparam int TOP_R1_CLR  = 9;
    localparam int TOP_R0_CLR  = 8;
    localparam int TOP_GEN_EN  = 2;
    localparam int TOP_HW_UPD  = 1;
    localparam int TOP_SW_UPD  = 0;

    localparam int CH_GO   = 14;
    localparam int CH_GON  = 13;
    localparam int CH_SS   = 12;
    localparam int CH_SSN  = 11;
    localparam int CH_MOE  = 10;
    localparam int CH_MOEN = 9;
    localparam int CH_DZE  = 8;
    localparam int CH_P    = 7;
    localparam int CH_NP   = 6;
    localparam int CH_E    = 5;
    localparam int CH_NE   = 4;

    // Flags plus the output-compare mode in bits 3..0, bit 15 reserved
    localparam ch_ctrl_t CH_CTRL_MASK = ch_ctrl_t'(
        (1 << CH_GO) | (1 << CH_GON) | (1 << CH_SS) | (1 << CH_SSN) |
        (1 << CH_MOE) | (1 << CH_MOEN) | (1 << CH_DZE) | (1 << CH_P) |
        (1 << CH_NP) | (1 << CH_E) | (1 << CH_NE)) | ch_ctrl_t'(oc_mode_t'('1));

    localparam int BRK_BT_LSB = 16;
    localparam int BRK_BK2P   = 13;
    localparam int BRK_BK2E   = 12;
    localparam int BRK_BK1P   = 11;
    localparam int BRK_BK1E   = 10;

    // Reset values
    localparam count_t     RST_PSC     = 16'h2;
    localparam count_t     RST_ARR     = 16'h32;
    localparam dead_time_t RST_DTG     = 10'h5;
    localparam ch_ctrl_t   RST_CH_CTRL = ch_ctrl_t'(1 << CH_DZE);

endpackage

`default_nettype wire

//--- hw/tim_cfg_top.sv
`timescale 1ns/100ps
`default_nettype none

module tim_cfg_top
    import tim_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  addr_t       paddr,
    input  data_t       pwdata,
    output data_t       prdata,
    output logic        r1_logic_clr,
    output logic        r0_logic_clr,
    output logic        gen_enable,
    output logic        hw_update_en,
    output logic        sw_update,
    output logic        dir,
    output count_t      psc,
    output count_t      arr,
    output count_t      rcr,
    output logic [1:0]  cms,
    output count_t      ch_compare [NUM_CH],
    output ch_ctrl_t    ch_ctrl [NUM_CH],
    output break_time_t bt,
    output logic        bk2p,
    output logic        bk2e,
    output logic        bk1p,
    output logic        bk1e,
    output dead_time_t  dtg,
    output logic [1:0]  int_en,
    output logic [1:0]  int_clr,
    input  logic [1:0]  int_sta
);

    data_t top_ctrl_img;
    data_t pe_ctrl_img;
    data_t pe_ctrl1_img;
    data_t pe_ctrl2_img;
    data_t ch_img [NUM_CH];
    data_t brk_img;
    data_t int_en_img;
    data_t int_clr_img;
    data_t int_sta_img;

    cfg_bus_if cfg_bus ();

    apb_reg_decode apb_reg_decode_inst (
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .cfg     (cfg_bus.decoder)
    );

    timebase_regs timebase_regs_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg_bus.bank),
        .r1_logic_clr (r1_logic_clr),
        .r0_logic_clr (r0_logic_clr),
        .gen_enable   (gen_enable),
        .hw_update_en (hw_update_en),
        .sw_update    (sw_update),
        .dir          (dir),
        .psc          (psc),
        .arr          (arr),
        .rcr          (rcr),
        .cms          (cms),
        .top_ctrl_img (top_ctrl_img),
        .pe_ctrl_img  (pe_ctrl_img),
        .pe_ctrl1_img (pe_ctrl1_img),
        .pe_ctrl2_img (pe_ctrl2_img)
    );

    output_stage_regs output_stage_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_bus.bank),
        .int_sta     (int_sta),
        .ch_compare  (ch_compare),
        .ch_ctrl     (ch_ctrl),
        .bt          (bt),
        .bk2p        (bk2p),
        .bk2e        (bk2e),
        .bk1p        (bk1p),
        .bk1e        (bk1e),
        .dtg         (dtg),
        .int_en      (int_en),
        .int_clr     (int_clr),
        .ch_img      (ch_img),
        .brk_img     (brk_img),
        .int_en_img  (int_en_img),
        .int_clr_img (int_clr_img),
        .int_sta_img (int_sta_img)
    );

    read_mux read_mux_inst (
        .cfg          (cfg_bus.reader),
        .top_ctrl_img (top_ctrl_img),
        .pe_ctrl_img  (pe_ctrl_img),
        .pe_ctrl1_img (pe_ctrl1_img),
        .pe_ctrl2_img (pe_ctrl2_img),
        .ch_img       (ch_img),
        .brk_img      (brk_img),
        .int_en_img   (int_en_img),
        .int_clr_img  (int_clr_img),
        .int_sta_img  (int_sta_img),
        .prdata       (prdata)
    );

endmodule

`default_nettype wire

//--- hw/timebase_regs.sv
`timescale 1ns/100ps
`default_nettype none

module timebase_regs
    import tim_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    cfg_bus_if.bank    cfg,
    output logic       r1_logic_clr,
    output logic       r0_logic_clr,
    output logic       gen_enable,
    output logic       hw_update_en,
    output logic       sw_update,
    output logic       dir,
    output count_t     psc,
    output count_t     arr,
    output count_t     rcr,
    output logic [1:0] cms,
    output data_t      top_ctrl_img,
    output data_t      pe_ctrl_img,
    output data_t      pe_ctrl1_img,
    output data_t      pe_ctrl2_img
);

    logic top_wr;
    logic pe_wr;
    logic pe1_wr;
    logic pe2_wr;

    assign top_wr = cfg.wr_en && (cfg.idx == IDX_TOP_CTRL);
    assign pe_wr  = cfg.wr_en && (cfg.idx == IDX_PE_CTRL);
    assign pe1_wr = cfg.wr_en && (cfg.idx == IDX_PE_CTRL1);
    assign pe2_wr = cfg.wr_en && (cfg.idx == IDX_PE_CTRL2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r1_logic_clr <= 1'b0;
            r0_logic_clr <= 1'b0;
            gen_enable   <= 1'b0;
            hw_update_en <= 1'b0;
            sw_update    <= 1'b0;
        end else if (top_wr) begin
            r1_logic_clr <= cfg.wdata[TOP_R1_CLR];
            r0_logic_clr <= cfg.wdata[TOP_R0_CLR];
            gen_enable   <= cfg.wdata[TOP_GEN_EN];
            hw_update_en <= cfg.wdata[TOP_HW_UPD];
            sw_update    <= cfg.wdata[TOP_SW_UPD];
        end
    end

    // Prescaler and auto-reload share one word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psc <= RST_PSC;
            arr <= RST_ARR;
        end else if (pe_wr) begin
            psc <= cfg.wdata[31:16];
            arr <= cfg.wdata[15:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rcr <= '0;
        end else if (pe1_wr) begin
            rcr <= cfg.wdata[31:16];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cms <= 2'b00;
            dir <= 1'b0;
        end else if (pe2_wr) begin
            cms <= cfg.wdata[2:1];
            dir <= cfg.wdata[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Read images
    ////////////////////////////////////////////////////////////
    assign top_ctrl_img = {22'h0, r1_logic_clr, r0_logic_clr, 5'h0,
                           gen_enable, hw_update_en, sw_update};
    assign pe_ctrl_img  = {psc, arr};
    assign pe_ctrl1_img = {rcr, 16'h0};
    assign pe_ctrl2_img = {29'h0, cms, dir};

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    // 4 ns period
    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tim_cfg_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tim_cfg_tb
    import tim_cfg_pkg::*;
();

    localparam addr_t TB_BASE       = 32'h4002_1000;
    localparam int    NUM_SLOTS     = 11;
    localparam int    STA_SLOT      = 10;
    localparam int    PHASE_TIMEOUT = 8;
    localparam int    WATCHDOG_STEPS = 200;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    addr_t       paddr;
    data_t       pwdata;
    data_t       prdata;
    logic        r1_logic_clr;
    logic        r0_logic_clr;
    logic        gen_enable;
    logic        hw_update_en;
    logic        sw_update;
    logic        dir;
    count_t      psc;
    count_t      arr;
    count_t      rcr;
    logic [1:0]  cms;
    count_t      ch_compare [NUM_CH];
    ch_ctrl_t    ch_ctrl [NUM_CH];
    break_time_t bt;
    logic        bk2p;
    logic        bk2e;
    logic        bk1p;
    logic        bk1e;
    dead_time_t  dtg;
    logic [1:0]  int_en;
    logic [1:0]  int_clr;
    logic [1:0]  int_sta;

    // Raw written words, one per kept register
    logic [NUM_SLOTS-1:0][31:0] model;

    integer seed;
    int     errors;
    int     checks;
    logic   done;
    addr_t  rd_addr;
    data_t  rd_data;
    event   read_sampled;

    tb_clk_gen tb_clk_gen_inst (
        .clk (clk)
    );

    tim_cfg_top tim_cfg_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .r1_logic_clr (r1_logic_clr),
        .r0_logic_clr (r0_logic_clr),
        .gen_enable   (gen_enable),
        .hw_update_en (hw_update_en),
        .sw_update    (sw_update),
        .dir          (dir),
        .psc          (psc),
        .arr          (arr),
        .rcr          (rcr),
        .cms          (cms),
        .ch_compare   (ch_compare),
        .ch_ctrl      (ch_ctrl),
        .bt           (bt),
        .bk2p         (bk2p),
        .bk2e         (bk2e),
        .bk1p         (bk1p),
        .bk1e         (bk1e),
        .dtg          (dtg),
        .int_en       (int_en),
        .int_clr      (int_clr),
        .int_sta      (int_sta)
    );

    ////////////////////////////////////////////////////////////
    // Register map of the timer as seen from the bus
    ////////////////////////////////////////////////////////////
    function automatic addr_t slot_offset(input int slot);
        case (slot)
            0:       return 32'h00;
            1:       return 32'h04;
            2:       return 32'h08;
            3:       return 32'h0C;
            4:       return 32'h10;
            5:       return 32'h14;
            6:       return 32'h18;
            7:       return 32'h28;
            8:       return 32'h40;
            9:       return 32'h44;
            default: return 32'h48;
        endcase
    endfunction

    function automatic int offset_slot(input addr_t offset);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (slot_offset(s) == offset) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic data_t writable_mask(input int slot);
        case (slot)
            0:       return 32'h0000_0307;
            1:       return 32'hFFFF_FFFF;
            2:       return 32'hFFFF_0000;
            3:       return 32'h0000_0007;
            4, 5, 6: return 32'hFFFF_7FFF;
            7:       return 32'h000F_3FFF;
            8, 9:    return 32'h0000_0003;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function automatic data_t expected_read(input addr_t offset,
                                            input logic [NUM_SLOTS-1:0][31:0] m);
        int slot;
        slot = offset_slot(offset);
        if (slot < 0) begin
            return '0;
        end
        if (slot == STA_SLOT) begin
            return {30'h0, int_sta};
        end
        return m[slot] & writable_mask(slot);
    endfunction

    function automatic addr_t unmapped_addr(input int i);
        case (i)
            0:       return TB_BASE + 32'h1C;
            1:       return TB_BASE + 32'h20;
            2:       return TB_BASE + 32'h24;
            3:       return TB_BASE + 32'h2C;
            4:       return TB_BASE + 32'h3C;
            5:       return TB_BASE + 32'h4C;
            6:       return TB_BASE + 32'h100;
            7:       return TB_BASE + 32'h1000;
            default: return 32'h0000_0010;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic check(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Read data is compared as soon as the access phase has sampled it
    always @(read_sampled) begin
        check($sformatf("prdata@%h", rd_addr), expected_read(rd_addr - TB_BASE, model),
              rd_data);
    end

    task automatic check_fields;
        check("r1_logic_clr", model[0][9], r1_logic_clr);
        check("r0_logic_clr", model[0][8], r0_logic_clr);
        check("gen_enable", model[0][2], gen_enable);
        check("hw_update_en", model[0][1], hw_update_en);
        check("sw_update", model[0][0], sw_update);
        check("psc", model[1][31:16], psc);
        check("arr", model[1][15:0], arr);
        check("rcr", model[2][31:16], rcr);
        check("cms", model[3][2:1], cms);
        check("dir", model[3][0], dir);
        for (int i = 0; i < NUM_CH; i++) begin
            check($sformatf("ch_compare[%0d]", i), model[4+i][31:16], ch_compare[i]);
            check($sformatf("ch_ctrl[%0d]", i), model[4+i][15:0] & 16'h7FFF, ch_ctrl[i]);
        end
        check("bt", model[7][19:16], bt);
        check("bk2p", model[7][13], bk2p);
        check("bk2e", model[7][12], bk2e);
        check("bk1p", model[7][11], bk1p);
        check("bk1e", model[7][10], bk1e);
        check("dtg", model[7][9:0], dtg);
        check("int_en", model[8][1:0], int_en);
        check("int_clr", model[9][1:0], int_clr);
    endtask

    ////////////////////////////////////////////////////////////
    // APB accesses, entered 1 ns after a rising edge
    ////////////////////////////////////////////////////////////
    task automatic wait_phase_edge(input logic want_enable);
        int n;
        n = 0;
        @(posedge clk);
        while (!(psel === 1'b1 && penable === want_enable) && n < PHASE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= PHASE_TIMEOUT) begin
            errors++;
            $display("APB phase did not reach its closing edge at t=%0t", $time);
        end
    endtask

    task automatic apb_write(input addr_t addr, input data_t data);
        psel    = 1'b1;
        pwrite  = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwdata  = data;
        wait_phase_edge(1'b0);
        #1;
        penable = 1'b1;
        wait_phase_edge(1'b1);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input addr_t addr);
        psel    = 1'b1;
        pwrite  = 1'b0;
        penable = 1'b0;
        paddr   = addr;
        wait_phase_edge(1'b0);
        #1;
        penable = 1'b1;
        // Mid access phase, prdata has settled
        #1;
        rd_addr = addr;
        rd_data = prdata;
        -> read_sampled;
        wait_phase_edge(1'b1);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_and_model(input addr_t addr, input data_t data);
        int slot;
        slot = offset_slot(addr - TB_BASE);
        apb_write(addr, data);
        if (slot >= 0 && slot != STA_SLOT) begin
            model[slot] = data;
        end
    endtask

    task automatic check_all_regs;
        check_fields();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            apb_read(TB_BASE + slot_offset(s));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        seed    = 32'h25c0_a440;
        errors  = 0;
        checks  = 0;
        done    = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        int_sta = 2'b00;
        model   = '0;
        model[1] = {16'h0002, 16'h0032};
        model[4] = 32'h0000_0100;
        model[5] = 32'h0000_0100;
        model[6] = 32'h0000_0100;
        model[7] = 32'h0000_0005;

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        // Reset values
        check_all_regs();

        // Random write, field ports, read back
        for (int round = 0; round < 3; round++) begin
            for (int s = 0; s < STA_SLOT; s++) begin
                write_and_model(TB_BASE + slot_offset(s), $random(seed));
                check_fields();
                apb_read(TB_BASE + slot_offset(s));
            end
        end

        // Status register follows int_sta and ignores writes
        for (int v = 0; v < 4; v++) begin
            int_sta = v[1:0];
            apb_read(TB_BASE + 32'h48);
        end
        write_and_model(TB_BASE + 32'h48, $random(seed));
        check_all_regs();

        // Dropped channels and other unmapped addresses
        for (int i = 0; i < 9; i++) begin
            apb_read(unmapped_addr(i));
            write_and_model(unmapped_addr(i), $random(seed));
            check_all_regs();
        end

        // Setup phase only, never enabled
        paddr   = TB_BASE + 32'h04;
        pwdata  = $random(seed);
        pwrite  = 1'b1;
        penable = 1'b0;
        psel    = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        psel   = 1'b0;
        pwrite = 1'b0;
        check_all_regs();

        // Enabled write without select
        paddr   = TB_BASE + 32'h10;
        pwdata  = $random(seed);
        pwrite  = 1'b1;
        penable = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        penable = 1'b0;
        pwrite  = 1'b0;
        check_all_regs();

        done = 1'b1;
        $display("Checks: %0d, errors: %0d, result %s", checks, errors,
                 (errors == 0) ? "PASS" : "FAIL");
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        for (int i = 0; i < WATCHDOG_STEPS && !done; i++) begin
            #100;
        end
        if (!done) begin
            $display("Timeout: stimulus did not complete within %0d ns",
                     WATCHDOG_STEPS * 100);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire
